//--- Makefile
TOP := pnmon_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)
	verilator --lint-only -f sources.f --top-module pnmon_top

clean:
	rm -rf obj_dir sim.log

//--- adc_pn_channel.sv
// *******************************************************************
// one monitor channel: reorders the samples of a beat, predicts the
// next beat with a self-seeding PN9/PN23 generator, posts status events
// *******************************************************************
`default_nettype none
`include "pnmon_settings.svh"

module adc_pn_channel (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`PNMON_BEAT_W-1:0] data,
  input  pnmon_pkg::pn_seq_e       seq_sel,
  output logic                     oos,
  status_bus_if.source             evt
);

  localparam int BW  = `PNMON_BEAT_W;
  localparam int RES = `PNMON_RESOLUTION;
  localparam int SPB = `PNMON_SAMPLES_PER_BEAT;
  // state must hold at least the 23 taps of PN23
  localparam int SW  = (BW > 23) ? BW : 23;
  localparam int DW  = pnmon_pkg::ERR_DELTA_W;
  localparam logic INV_MSB = 1'(`PNMON_TWOS_COMPLEMENT == 0);

  logic [BW-1:0]    rx_s;
  logic [BW-1:0]    rx_q;
  logic [SW-1:0]    seed;
  logic [SW-1:0]    pn_q;
  logic [BW-1:0]    pn_next;
  logic [SW+BW-1:0] pn_hist;
  logic             mismatch;
  logic             sent_oos;
  logic [DW-1:0]    acc_q;
  logic [DW-1:0]    delta;
  logic             slot_free;

  // *****************************************************************
  // sample reorder and format
  // *****************************************************************

  // sample 0 is first in time and lands in the word msbs
  for (genvar i = 0; i < SPB; i++) begin : g_swizzle
    localparam int SRC = i * RES;
    localparam int DST = (SPB - 1 - i) * RES;
    assign rx_s[DST+RES-1] = data[SRC+RES-1] ^ INV_MSB;
    assign rx_s[DST+RES-2 -: RES-1] = data[SRC+RES-2 -: RES-1];
  end

  always_ff @(posedge clk) begin
    rx_q <= rx_s;
  end

  // *****************************************************************
  // PN generator
  // *****************************************************************

  // next beat from the last SW bits, bit 0 of st is the latest bit
  function automatic logic [BW-1:0] pn_step(logic [SW-1:0] st, pnmon_pkg::pn_seq_e sel);
    logic [SW+BW-1:0] full;
    full = {st, {BW{1'b0}}};
    // walk from oldest to newest so every tap is already known
    for (int i = BW - 1; i >= 0; i--) begin
      if (sel == pnmon_pkg::PN9) begin
        full[i] = full[i+9] ^ full[i+5];
      end else begin
        full[i] = full[i+23] ^ full[i+18];
      end
    end
    return full[BW-1:0];
  endfunction

  // out of sync, seed from the received data
  if (SW > BW) begin : g_tail
    // short beats need older bits from the previous beat
    logic [SW-BW-1:0] tail_q;
    always_ff @(posedge clk) begin
      tail_q <= rx_q[SW-BW-1:0];
    end
    assign seed = oos ? {tail_q, rx_q} : pn_q;
  end else begin : g_no_tail
    assign seed = oos ? rx_q : pn_q;
  end

  assign pn_next = pn_step(seed, seq_sel);
  assign pn_hist = {seed, pn_next};

  // pn_q predicts the beat held in rx_q
  always_ff @(posedge clk) begin
    pn_q <= pn_hist[SW-1:0];
  end

  pn_lock_checker u_lock (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_word  (rx_q),
    .pn_word  (pn_q[BW-1:0]),
    .oos      (oos),
    .mismatch (mismatch)
  );

  // *****************************************************************
  // event posting
  // *****************************************************************

  assign slot_free = !evt.valid || evt.ready;
  // errors seen while an event waits go into the next one
  assign delta = (acc_q == '1) ? acc_q : acc_q + DW'(mismatch);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      evt.valid   <= 1'b0;
      evt.payload <= '0;
      sent_oos    <= 1'b1;
      acc_q       <= '0;
    end else if (slot_free) begin
      // post only on a state change or new errors
      if (oos != sent_oos || delta != '0) begin
        evt.valid             <= 1'b1;
        evt.payload.oos       <= oos;
        evt.payload.err_delta <= delta;
        sent_oos              <= oos;
      end else begin
        evt.valid <= 1'b0;
      end
      acc_q <= '0;
    end else begin
      acc_q <= delta;
    end
  end

endmodule

`default_nettype wire

//--- pn_lock_checker.sv
// *******************************************************************
// lock state of one channel: compares received and predicted beats
// and tracks out-of-sync with match and mismatch run thresholds
// *******************************************************************
`default_nettype none
`include "pnmon_settings.svh"

module pn_lock_checker (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`PNMON_BEAT_W-1:0] rx_word,
  input  logic [`PNMON_BEAT_W-1:0] pn_word,
  output logic                     oos,
  output logic                     mismatch
);

  localparam int LOCK_N   = `PNMON_LOCK_MATCHES;
  localparam int UNLOCK_N = `PNMON_UNLOCK_MISMATCHES;
  localparam int RUN_MAX  = (LOCK_N > UNLOCK_N) ? LOCK_N : UNLOCK_N;
  localparam int RUN_W    = $clog2(RUN_MAX + 1);

  logic             match;
  // one run counter serves both states, cleared on every transition
  logic [RUN_W-1:0] run_cnt;

  assign match = (rx_word == pn_word);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      oos      <= 1'b1;
      mismatch <= 1'b0;
      run_cnt  <= '0;
    end else begin
      // errors only count while in sync
      mismatch <= !oos && !match;
      if (oos) begin
        // out of sync, wait for a run of clean beats
        if (!match) begin
          run_cnt <= '0;
        end else if (run_cnt == RUN_W'(LOCK_N - 1)) begin
          oos     <= 1'b0;
          run_cnt <= '0;
        end else begin
          run_cnt <= run_cnt + 1'b1;
        end
      end else begin
        // in sync, drop lock after a run of bad beats
        if (match) begin
          run_cnt <= '0;
        end else if (run_cnt == RUN_W'(UNLOCK_N - 1)) begin
          oos     <= 1'b1;
          run_cnt <= '0;
        end else begin
          run_cnt <= run_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- pnmon_pkg.sv
// *******************************************************************
// shared types of the PN monitor: sequence select, status event
// record and register field widths
// *******************************************************************
`default_nettype none

package pnmon_pkg;

  // sequence select, one bit per channel in the control register
  typedef enum logic {
    PN9  = 1'b0,   // x^9 + x^5 + 1
    PN23 = 1'b1    // x^23 + x^18 + 1
  } pn_seq_e;

  // field widths
  localparam int ERR_DELTA_W = 8;
  localparam int ERR_COUNT_W = 16;

  // one status event, posted by a channel towards the register block
  typedef struct packed {
    logic                   oos;
    logic [ERR_DELTA_W-1:0] err_delta;   // saturating
  } status_event_t;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- pnmon_properties.sv
// *******************************************************************
// AXI4-Lite handshake assertions, bound into the register block
// *******************************************************************
`default_nettype none
`include "pnmon_settings.svh"

module pnmon_properties (
  input logic                     clk,
  input logic                     rst_n,
  input logic [`PNMON_ADDR_W-1:0] awaddr,
  input logic                     awvalid,
  input logic                     wvalid,
  input logic [1:0]               bresp,
  input logic                     bvalid,
  input logic                     bready,
  input logic [31:0]              rdata,
  input logic                     rvalid,
  input logic                     rready
);

  timeunit 1ns;
  timeprecision 100ps;

  logic mapped;

  // control word or one of the status words
  assign mapped = (awaddr == `PNMON_ADDR_CTRL) ||
                  ((awaddr >= `PNMON_ADDR_STATUS_BASE) &&
                   (awaddr < `PNMON_ADDR_STATUS_BASE + 4 * `PNMON_NUM_CHANNELS) &&
                   (awaddr[1:0] == 2'b00));

  // write response stays up until taken
  a_bvalid_hold : assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // read response and its data stay put until taken
  a_rvalid_hold : assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

  // mapped writes answer OKAY
  a_bresp_okay : assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && wvalid && !bvalid && mapped |=> bresp == 2'b00)
    else $error("write to a mapped address did not answer OKAY");

endmodule

`default_nettype wire

//--- pnmon_regs.sv
// *******************************************************************
// AXI4-Lite slave with the sequence select register and one status
// register per channel, updated from the arbiter's events
// *******************************************************************
`default_nettype none
`include "pnmon_settings.svh"

module pnmon_regs (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [`PNMON_ADDR_W-1:0]                      awaddr,
  input  logic                                          awvalid,
  output logic                                          awready,
  input  logic [31:0]                                   wdata,
  input  logic [3:0]                                    wstrb,
  input  logic                                          wvalid,
  output logic                                          wready,
  output logic [1:0]                                    bresp,
  output logic                                          bvalid,
  input  logic                                          bready,
  input  logic [`PNMON_ADDR_W-1:0]                      araddr,
  input  logic                                          arvalid,
  output logic                                          arready,
  output logic [31:0]                                   rdata,
  output logic [1:0]                                    rresp,
  output logic                                          rvalid,
  input  logic                                          rready,
  input  logic                                          upd_valid,
  input  logic [`PNMON_CHAN_W-1:0]                      upd_chan,
  input  pnmon_pkg::status_event_t                      upd_event,
  output pnmon_pkg::pn_seq_e [`PNMON_NUM_CHANNELS-1:0]  seq_sel
);

  localparam int N     = `PNMON_NUM_CHANNELS;
  localparam int CW    = `PNMON_CHAN_W;
  localparam int AW    = `PNMON_ADDR_W;
  localparam int CNT_W = pnmon_pkg::ERR_COUNT_W;
  localparam int DW    = pnmon_pkg::ERR_DELTA_W;

  logic [N-1:0]     ctrl_q;
  logic [N-1:0]     stat_oos;
  logic [N-1:0]     stat_err;
  logic [CNT_W-1:0] stat_cnt [N];
  logic             wr_take;
  logic             rd_take;
  logic             wr_ctrl;
  logic             wr_stat;
  logic             wr_clear;
  logic [CW-1:0]    wr_chan;
  logic [CW-1:0]    rd_chan;
  logic [31:0]      wmask;
  logic [31:0]      ctrl_merge;
  logic [31:0]      rd_word;
  logic             rd_ok;

  // status words sit on a 4 byte stride after the base
  function automatic logic is_status(logic [AW-1:0] addr);
    return (addr >= `PNMON_ADDR_STATUS_BASE) && (addr < `PNMON_ADDR_STATUS_BASE + 4 * N)
           && (addr[1:0] == 2'b00);
  endfunction

  function automatic logic [CW-1:0] chan_of(logic [AW-1:0] addr);
    logic [AW-1:0] offs;
    offs = addr - `PNMON_ADDR_STATUS_BASE;
    return offs[CW+1:2];
  endfunction

  function automatic logic [CNT_W-1:0] sat_add(logic [CNT_W-1:0] cnt, logic [DW-1:0] d);
    logic [CNT_W:0] sum;
    sum = {1'b0, cnt} + {{(CNT_W + 1 - DW){1'b0}}, d};
    return sum[CNT_W] ? '1 : sum[CNT_W-1:0];
  endfunction

  // *****************************************************************
  // write channel
  // *****************************************************************

  // address and data taken together, one outstanding response
  assign wr_take  = awvalid && wvalid && !bvalid;
  assign awready  = wr_take;
  assign wready   = wr_take;
  assign wr_ctrl  = (awaddr == `PNMON_ADDR_CTRL);
  assign wr_stat  = is_status(awaddr);
  assign wr_chan  = chan_of(awaddr);
  // write 1 to bit 1 clears sticky bit and count
  assign wr_clear = wr_take && wr_stat && wstrb[0] && wdata[1];

  for (genvar b = 0; b < 4; b++) begin : g_mask
    assign wmask[8*b +: 8] = {8{wstrb[b]}};
  end
  assign ctrl_merge = ({{(32 - N){1'b0}}, ctrl_q} & ~wmask) | (wdata & wmask);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      bresp  <= pnmon_pkg::RESP_OKAY;
      ctrl_q <= '0;
    end else if (wr_take) begin
      bvalid <= 1'b1;
      bresp  <= (wr_ctrl || wr_stat) ? pnmon_pkg::RESP_OKAY : pnmon_pkg::RESP_SLVERR;
      if (wr_ctrl) begin
        ctrl_q <= ctrl_merge[N-1:0];
      end
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  for (genvar c = 0; c < N; c++) begin : g_sel
    assign seq_sel[c] = pnmon_pkg::pn_seq_e'(ctrl_q[c]);
  end

  // *****************************************************************
  // read channel
  // *****************************************************************

  assign rd_take = arvalid && !rvalid;
  assign arready = rd_take;
  assign rd_chan = chan_of(araddr);

  // unmapped reads return zero
  always_comb begin
    rd_word = '0;
    rd_ok   = 1'b0;
    if (araddr == `PNMON_ADDR_CTRL) begin
      rd_ok          = 1'b1;
      rd_word[N-1:0] = ctrl_q;
    end else if (is_status(araddr)) begin
      rd_ok               = 1'b1;
      rd_word[16 +: CNT_W] = stat_cnt[rd_chan];
      rd_word[1]          = stat_err[rd_chan];
      rd_word[0]          = stat_oos[rd_chan];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= pnmon_pkg::RESP_OKAY;
    end else if (rd_take) begin
      rvalid <= 1'b1;
      rdata  <= rd_word;
      rresp  <= rd_ok ? pnmon_pkg::RESP_OKAY : pnmon_pkg::RESP_SLVERR;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // *****************************************************************
  // status registers
  // *****************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stat_oos <= '0;
      stat_err <= '0;
      for (int c = 0; c < N; c++) begin
        stat_cnt[c] <= '0;
      end
    end else begin
      for (int c = 0; c < N; c++) begin
        // an event in the same cycle beats the clear
        if (upd_valid && upd_chan == CW'(c)) begin
          stat_oos[c] <= upd_event.oos;
          stat_cnt[c] <= sat_add(stat_cnt[c], upd_event.err_delta);
          if (upd_event.err_delta != '0) begin
            stat_err[c] <= 1'b1;
          end
        end else if (wr_clear && wr_chan == CW'(c)) begin
          stat_err[c] <= 1'b0;
          stat_cnt[c] <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- pnmon_settings.svh
// *******************************************************************
// build-time settings of the PN monitor: channel geometry, input
// format, lock thresholds and the AXI4-Lite register map
// *******************************************************************
`ifndef PNMON_SETTINGS_SVH
`define PNMON_SETTINGS_SVH

// channel geometry
`define PNMON_NUM_CHANNELS      2
`define PNMON_RESOLUTION        16
`define PNMON_SAMPLES_PER_BEAT  2
`define PNMON_BEAT_W            (`PNMON_RESOLUTION * `PNMON_SAMPLES_PER_BEAT)
`define PNMON_CHAN_W            ((`PNMON_NUM_CHANNELS > 1) ? $clog2(`PNMON_NUM_CHANNELS) : 1)

// 1 for two's complement input, 0 for offset binary
`define PNMON_TWOS_COMPLEMENT   1

// lock thresholds, counted in beats
`define PNMON_LOCK_MATCHES      16
`define PNMON_UNLOCK_MISMATCHES 8

// register map, byte offsets
`define PNMON_ADDR_W            8
`define PNMON_ADDR_CTRL         8'h00
`define PNMON_ADDR_STATUS_BASE  8'h10

`endif

//--- pnmon_tb.sv
// *******************************************************************
// table-driven testbench of the PN monitor: streams PN9/PN23 beats,
// corrupts chosen beats and checks the status registers over AXI4-Lite
// *******************************************************************
`default_nettype none
`include "pnmon_settings.svh"

module pnmon_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N      = `PNMON_NUM_CHANNELS;
  localparam int SETTLE = 32;
  localparam int ROWS   = 6;

  // one test step
  typedef struct packed {
    logic [1:0]  seq;       // control word, bit c selects PN23 on channel c
    logic        clr;       // write-1 clear of both status words first
    logic [7:0]  bad0;
    logic [7:0]  bad1;
    logic [1:0]  burst;     // bit c set: corrupted beats back to back
    logic [7:0]  clean;     // clean beats after the corrupted ones
    logic [1:0]  oos_end;   // raw pn_oos once the beats are sent
    logic [1:0]  oos;
    logic [1:0]  err;
    logic [15:0] cnt0;
    logic [15:0] cnt1;
  } row_t;

  logic                 clk;
  logic                 rst_n;
  logic [N-1:0][31:0]   adc_data;
  logic [7:0]           awaddr;
  logic                 awvalid;
  logic                 awready;
  logic [31:0]          wdata;
  logic [3:0]           wstrb;
  logic                 wvalid;
  logic                 wready;
  logic [1:0]           bresp;
  logic                 bvalid;
  logic                 bready;
  logic [7:0]           araddr;
  logic                 arvalid;
  logic                 arready;
  logic [31:0]          rdata;
  logic [1:0]           rresp;
  logic                 rvalid;
  logic                 rready;
  logic [N-1:0]         pn_oos;

  row_t         table_q [ROWS];
  logic [63:0]  beat_q [$];
  logic [31:0]  hist [N];
  logic [1:0]   seq_model;
  logic [31:0]  lfsr_q;
  int           cycles;
  int           limit;

  tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  pnmon_top UUT (
    .clk(clk), .rst_n(rst_n), .adc_data(adc_data),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .pn_oos(pn_oos)
  );

  bind pnmon_regs pnmon_properties u_props (
    .clk(clk), .rst_n(rst_n), .awaddr(awaddr), .awvalid(awvalid),
    .wvalid(wvalid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .rdata(rdata), .rvalid(rvalid), .rready(rready)
  );

  // *****************************************************************
  // reference model and random bits
  // *****************************************************************

  // 32-bit fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // next 32 bits of the sequence, bit 0 of h is the newest bit
  function automatic logic [31:0] pn_beat(logic [31:0] h, logic pn23);
    logic nb;
    for (int i = 0; i < 32; i++) begin
      nb = pn23 ? (h[22] ^ h[17]) : (h[8] ^ h[4]);
      h = {h[30:0], nb};
    end
    return h;
  endfunction

  // first sample in time travels in the low half of the bus
  function automatic logic [31:0] to_bus(logic [31:0] w);
    logic [31:0] d;
    d = {w[15:0], w[31:16]};
    if (`PNMON_TWOS_COMPLEMENT == 0) begin
      d[31] = ~d[31];
      d[15] = ~d[15];
    end
    return d;
  endfunction

  // *****************************************************************
  // checks and bus tasks
  // *****************************************************************

  task automatic check(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic axi_write(logic [7:0] addr, logic [31:0] data);
    @(posedge clk);
    #10;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    forever begin
      @(posedge clk);
      if (awready) break;
    end
    #10;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    // leave the response waiting a cycle before taking it
    @(posedge clk);
    #10;
    bready = 1'b1;
    forever begin
      @(posedge clk);
      if (bvalid) break;
    end
    #10;
    bready = 1'b0;
    check("write response", 32'(bresp), 32'(pnmon_pkg::RESP_OKAY));
  endtask

  task automatic axi_read(logic [7:0] addr, output logic [31:0] data, output logic [1:0] resp);
    @(posedge clk);
    #10;
    araddr  = addr;
    arvalid = 1'b1;
    forever begin
      @(posedge clk);
      if (arready) break;
    end
    #10;
    arvalid = 1'b0;
    // leave the response waiting a cycle before taking it
    @(posedge clk);
    #10;
    rready = 1'b1;
    forever begin
      @(posedge clk);
      if (rvalid) break;
    end
    data = rdata;
    resp = rresp;
    #10;
    rready = 1'b0;
  endtask

  // *****************************************************************
  // beat stream, one beat per cycle, masks taken from the queue
  // *****************************************************************

  always @(posedge clk) begin
    logic [63:0] m;
    #10;
    m = (beat_q.size() != 0) ? beat_q.pop_front() : '0;
    for (int c = 0; c < N; c++) begin
      hist[c] = pn_beat(hist[c], seq_model[c]);
      adc_data[c] = to_bus(hist[c] ^ m[32*c +: 32]);
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: the run passed %0d cycles without finishing", limit);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  // *****************************************************************
  // test sequence
  // *****************************************************************

  initial begin
    logic [31:0] rd;
    logic [1:0]  rsp;
    logic [31:0] m0;
    logic [31:0] m1;
    int          n0;
    int          n1;
    int          n;
    //              seq    clr   bad0   bad1   burst  clean  oend   oos    err    cnt0    cnt1
    table_q[0] = '{2'b10, 1'b0, 8'd0,  8'd0,  2'b00, 8'd40, 2'b00, 2'b00, 2'b00, 16'd0,  16'd0};
    table_q[1] = '{2'b10, 1'b0, 8'd3,  8'd1,  2'b00, 8'd8,  2'b00, 2'b00, 2'b11, 16'd3,  16'd1};
    table_q[2] = '{2'b10, 1'b0, 8'd60, 8'd60, 2'b11, 8'd0,  2'b11, 2'b00, 2'b11, 16'd11, 16'd9};
    table_q[3] = '{2'b10, 1'b1, 8'd5,  8'd5,  2'b00, 8'd8,  2'b00, 2'b00, 2'b11, 16'd5,  16'd5};
    table_q[4] = '{2'b10, 1'b1, 8'd0,  8'd0,  2'b00, 8'd8,  2'b00, 2'b00, 2'b00, 16'd0,  16'd0};
    table_q[5] = '{2'b00, 1'b0, 8'd0,  8'd0,  2'b00, 8'd16, 2'b10, 2'b10, 2'b10, 16'd0,  16'd8};

    lfsr_q    = 32'h3e9a_c4e6;
    cycles    = 0;
    // streams keep the first row's sequences, a later row may select another one
    seq_model = table_q[0].seq;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = 4'hf;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    adc_data  = '0;
    for (int c = 0; c < N; c++) begin
      hist[c] = rand_bits(32) | 32'h1;
    end
    // beats of each row plus axi traffic, settle window and margin
    limit = 400;
    for (int r = 0; r < ROWS; r++) begin
      limit = limit + 4 * int'(table_q[r].bad0) + 4 * int'(table_q[r].bad1)
              + int'(table_q[r].clean) + SETTLE + 80;
    end

    // state right after reset
    wait (rst_n);
    @(posedge clk);
    check("pn_oos after reset", 32'(pn_oos), 32'h3);
    for (int c = 0; c < N; c++) begin
      axi_read(8'(`PNMON_ADDR_STATUS_BASE + 4 * c), rd, rsp);
      check("status after reset", rd, 32'h0);
      check("status read response", 32'(rsp), 32'(pnmon_pkg::RESP_OKAY));
    end

    for (int r = 0; r < ROWS; r++) begin
      axi_write(`PNMON_ADDR_CTRL, 32'(table_q[r].seq));
      if (table_q[r].clr) begin
        for (int c = 0; c < N; c++) begin
          axi_write(8'(`PNMON_ADDR_STATUS_BASE + 4 * c), 32'h2);
        end
      end
      // isolated errors sit 4 beats apart
      n0 = table_q[r].burst[0] ? int'(table_q[r].bad0) : 4 * int'(table_q[r].bad0);
      n1 = table_q[r].burst[1] ? int'(table_q[r].bad1) : 4 * int'(table_q[r].bad1);
      n  = ((n0 > n1) ? n0 : n1) + int'(table_q[r].clean);
      for (int i = 0; i < n; i++) begin
        m0 = '0;
        m1 = '0;
        if (table_q[r].burst[0] ? (i < n0) : (i < n0 && i % 4 == 0)) begin
          m0 = rand_bits(32) | 32'h1;
        end
        if (table_q[r].burst[1] ? (i < n1) : (i < n1 && i % 4 == 0)) begin
          m1 = rand_bits(32) | 32'h1;
        end
        beat_q.push_back({m1, m0});
      end
      while (beat_q.size() != 0) @(posedge clk);
      check("pn_oos at end of beats", 32'(pn_oos), 32'(table_q[r].oos_end));
      repeat (SETTLE) @(posedge clk);
      axi_read(`PNMON_ADDR_STATUS_BASE, rd, rsp);
      check("status of channel 0", rd,
            {table_q[r].cnt0, 14'h0, table_q[r].err[0], table_q[r].oos[0]});
      check("status read response", 32'(rsp), 32'(pnmon_pkg::RESP_OKAY));
      axi_read(8'(`PNMON_ADDR_STATUS_BASE + 4), rd, rsp);
      check("status of channel 1", rd,
            {table_q[r].cnt1, 14'h0, table_q[r].err[1], table_q[r].oos[1]});
      check("status read response", 32'(rsp), 32'(pnmon_pkg::RESP_OKAY));
    end

    // unmapped address
    axi_read(8'h40, rd, rsp);
    check("unmapped read data", rd, 32'h0);
    check("unmapped read response", 32'(rsp), 32'(pnmon_pkg::RESP_SLVERR));

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- pnmon_top.sv
// *******************************************************************
// top of the two-channel PN monitor: channel checkers, status
// arbiter and AXI4-Lite registers
// *******************************************************************
`default_nettype none
`include "pnmon_settings.svh"

module pnmon_top (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic [`PNMON_NUM_CHANNELS-1:0][`PNMON_BEAT_W-1:0] adc_data,
  input  logic [`PNMON_ADDR_W-1:0]                          awaddr,
  input  logic                                              awvalid,
  output logic                                              awready,
  input  logic [31:0]                                       wdata,
  input  logic [3:0]                                        wstrb,
  input  logic                                              wvalid,
  output logic                                              wready,
  output logic [1:0]                                        bresp,
  output logic                                              bvalid,
  input  logic                                              bready,
  input  logic [`PNMON_ADDR_W-1:0]                          araddr,
  input  logic                                              arvalid,
  output logic                                              arready,
  output logic [31:0]                                       rdata,
  output logic [1:0]                                        rresp,
  output logic                                              rvalid,
  input  logic                                              rready,
  output logic [`PNMON_NUM_CHANNELS-1:0]                    pn_oos
);

  localparam int N = `PNMON_NUM_CHANNELS;

  logic                                 upd_valid;
  logic [`PNMON_CHAN_W-1:0]             upd_chan;
  pnmon_pkg::status_event_t             upd_event;
  pnmon_pkg::pn_seq_e [N-1:0]           seq_sel;

  // one event link per channel
  status_bus_if bus [N] ();

  for (genvar c = 0; c < N; c++) begin : g_chan
    adc_pn_channel u_chan (
      .clk     (clk),
      .rst_n   (rst_n),
      .data    (adc_data[c]),
      .seq_sel (seq_sel[c]),
      .oos     (pn_oos[c]),
      .evt     (bus[c])
    );
  end

  status_arbiter u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (bus),
    .upd_valid (upd_valid),
    .upd_chan  (upd_chan),
    .upd_event (upd_event)
  );

  pnmon_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .upd_valid (upd_valid),
    .upd_chan  (upd_chan),
    .upd_event (upd_event),
    .seq_sel   (seq_sel)
  );

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
pnmon_pkg.sv
status_bus_if.sv
pn_lock_checker.sv
adc_pn_channel.sv
status_arbiter.sv
pnmon_regs.sv
pnmon_top.sv
tb_clock_gen.sv
pnmon_properties.sv
pnmon_tb.sv

//--- status_arbiter.sv
// *******************************************************************
// round-robin arbiter that forwards one channel's status event per
// cycle to the register block, which always accepts
// *******************************************************************
`default_nettype none
`include "pnmon_settings.svh"

module status_arbiter (
  input  logic                          clk,
  input  logic                          rst_n,
  status_bus_if.sink                    req [`PNMON_NUM_CHANNELS],
  output logic                          upd_valid,
  output logic [`PNMON_CHAN_W-1:0]      upd_chan,
  output pnmon_pkg::status_event_t      upd_event
);

  localparam int N  = `PNMON_NUM_CHANNELS;
  localparam int CW = `PNMON_CHAN_W;

  logic [N-1:0]             req_valid;
  pnmon_pkg::status_event_t req_payload [N];
  logic [CW-1:0]            last_q;
  logic [CW-1:0]            gnt_idx;
  logic                     found;

  // flatten the interface array, ready goes to the winner only
  for (genvar i = 0; i < N; i++) begin : g_req
    assign req_valid[i]   = req[i].valid;
    assign req_payload[i] = req[i].payload;
    assign req[i].ready   = found && (gnt_idx == CW'(i));
  end

  // first requester after the last grant
  always_comb begin
    found   = 1'b0;
    gnt_idx = last_q;
    for (int k = 1; k <= N; k++) begin
      if (!found && req_valid[(int'(last_q) + k) % N]) begin
        found   = 1'b1;
        gnt_idx = CW'((int'(last_q) + k) % N);
      end
    end
  end

  // pointer starts on the last channel so channel 0 wins first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q <= CW'(N - 1);
    end else if (found) begin
      last_q <= gnt_idx;
    end
  end

  assign upd_valid = found;
  assign upd_chan  = gnt_idx;
  assign upd_event = req_payload[gnt_idx];

endmodule

`default_nettype wire

//--- status_bus_if.sv
// *******************************************************************
// valid/ready status event link from one channel to the arbiter
// *******************************************************************
`default_nettype none

interface status_bus_if;

  logic                     valid;
  logic                     ready;
  // payload held stable while valid and not ready
  pnmon_pkg::status_event_t payload;

  // channel side
  modport source (output valid, output payload, input ready);
  // arbiter side
  modport sink (input valid, input payload, output ready);

endinterface

`default_nettype wire

//--- tb_clock_gen.sv
// *******************************************************************
// testbench clock (100 ns period) and active-low reset held for the
// first 5 rising edges
// *******************************************************************
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    // release a little after the edge, like the other inputs
    repeat (5) @(posedge clk);
    #10 rst_n = 1'b1;
  end

  always #50 clk = ~clk;

endmodule

`default_nettype wire
